//--- hdl/trace_pkg.sv
package trace_pkg;

  // pipeline widths
  localparam int num_rules      = 8;
  localparam int buf_width      = 64;
  localparam int nibble_width   = 4;
  localparam int stamp_width    = 16;
  localparam int count_width    = 8;
  localparam int rule_idx_width = 3;

  // apb side
  localparam int apb_addr_width = 8;
  localparam int apb_data_width = 32;
  localparam int word_width     = apb_addr_width - 2; // byte address to word number

  // register map in word offsets
  localparam logic [word_width-1:0] reg_ctrl      = 'd0; // [7:0] pattern_enable, [15:8] trig_enable
  localparam logic [word_width-1:0] reg_status    = 'd1; // bit 0 overflow, write 1 to clear
  localparam logic [word_width-1:0] reg_count_lo  = 'd2; // counts 0..3
  localparam logic [word_width-1:0] reg_count_hi  = 'd3; // counts 4..7
  localparam logic [word_width-1:0] reg_rule_base = 'd8;

  // pattern lo, pattern hi, mask lo, mask hi
  localparam int rule_words = 4;

  // stage 1 output
  typedef struct packed {
    logic [buf_width-1:0]   data;
    logic [stamp_width-1:0] stamp;
    logic                   valid;
  } trace_buf_t;

  // stage 2 output
  typedef struct packed {
    logic [num_rules-1:0]   match;
    logic [stamp_width-1:0] stamp;
  } match_vec_t;

  // one match rule
  typedef struct packed {
    logic [buf_width-1:0] pattern;
    logic [buf_width-1:0] mask;
  } rule_cfg_t;

  // event leaving the top level
  typedef struct packed {
    logic [rule_idx_width-1:0] rule;
    logic [stamp_width-1:0]    stamp;
  } trace_event_t;

  // counter r lives in [r]
  typedef logic [num_rules-1:0][count_width-1:0] count_vec_t;

endpackage

//--- hdl/trace_apb_regs.sv
`timescale 1ns/10ps

module trace_apb_regs (
  input  logic                                       fe_clk,
  input  logic                                       reset,
  // apb slave
  input  logic [trace_pkg::apb_addr_width-1:0]       paddr,
  input  logic                                       psel,
  input  logic                                       penable,
  input  logic                                       pwrite,
  input  logic [trace_pkg::apb_data_width-1:0]       pwdata,
  output logic [trace_pkg::apb_data_width-1:0]       prdata,
  output logic                                       pready,
  output logic                                       pslverr,
  // configuration out
  output trace_pkg::rule_cfg_t [trace_pkg::num_rules-1:0] rules,
  output logic [trace_pkg::num_rules-1:0]            pattern_enable,
  output logic [trace_pkg::num_rules-1:0]            trig_enable,
  output logic                                       clear_overflow,
  // status in
  input  trace_pkg::count_vec_t                      counts,
  input  logic                                       overflow
);
  import trace_pkg::*;

  logic [word_width-1:0]     word;
  logic [word_width-1:0]     rule_rel;
  logic [rule_idx_width-1:0] rule_sel;
  logic [1:0]                rule_part;
  logic                      rule_hit;
  logic                      mapped;
  logic                      access;
  logic                      wr_en;

  assign word      = paddr[apb_addr_width-1:2];
  assign rule_rel  = word - reg_rule_base;
  assign rule_sel  = rule_rel[rule_idx_width+1:2];
  assign rule_part = rule_rel[1:0];
  assign rule_hit  = (word >= reg_rule_base) &&
                     (int'(word) < int'(reg_rule_base) + rule_words * num_rules);

  // words 4..7 are a hole in the map
  assign mapped = rule_hit || (word == reg_ctrl) || (word == reg_status) ||
                  (word == reg_count_lo) || (word == reg_count_hi);

  assign access  = psel && penable;
  assign wr_en   = access && pwrite && mapped;
  assign pready  = 1'b1; // zero wait states
  assign pslverr = access && !mapped;

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      pattern_enable <= '0;
      trig_enable    <= '0;
      rules          <= '0;
      clear_overflow <= 1'b0;
    end else begin
      clear_overflow <= wr_en && (word == reg_status) && pwdata[0];
      if (wr_en && (word == reg_ctrl)) begin
        pattern_enable <= pwdata[7:0];
        trig_enable    <= pwdata[15:8];
      end
      if (wr_en && rule_hit) begin
        case (rule_part)
          2'd0:    rules[rule_sel].pattern[31:0]  <= pwdata;
          2'd1:    rules[rule_sel].pattern[63:32] <= pwdata;
          2'd2:    rules[rule_sel].mask[31:0]     <= pwdata;
          default: rules[rule_sel].mask[63:32]    <= pwdata;
        endcase
      end
    end
  end

  // readback mux with read-only count words
  always_comb begin
    prdata = '0;
    if (access) begin
      if (rule_hit) begin
        case (rule_part)
          2'd0:    prdata = rules[rule_sel].pattern[31:0];
          2'd1:    prdata = rules[rule_sel].pattern[63:32];
          2'd2:    prdata = rules[rule_sel].mask[31:0];
          default: prdata = rules[rule_sel].mask[63:32];
        endcase
      end else begin
        case (word)
          reg_ctrl:     prdata = {16'h0000, trig_enable, pattern_enable};
          reg_status:   prdata = {31'd0, overflow};
          reg_count_lo: prdata = counts[3:0];
          reg_count_hi: prdata = counts[7:4];
          default:      prdata = '0;
        endcase
      end
    end
  end

  // apb protocol from the requester side
  penable_needs_psel: assert property (
    @(posedge fe_clk) disable iff (reset) penable |-> psel);

  psel_held_into_access: assert property (
    @(posedge fe_clk) disable iff (reset) (psel && !penable) |=> psel);

endmodule

//--- hdl/trace_shifter.sv
`timescale 1ns/10ps

module trace_shifter (
  input  logic                              fe_clk,
  input  logic                              reset,
  input  logic [trace_pkg::nibble_width-1:0] trace_data,
  input  logic                              trace_valid,
  output trace_pkg::trace_buf_t             buf_out
);
  import trace_pkg::*;

  logic [stamp_width-1:0] stamp;     // free running cycle count
  logic [buf_width-1:0]   shift_buf;
  logic [stamp_width-1:0] buf_stamp; // stamp of the newest nibble
  logic                   buf_valid;

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      stamp <= '0;
    end else begin
      stamp <= stamp + 1'b1;
    end
  end

  // newest nibble lands in [3:0], oldest falls off the top
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      shift_buf <= '0;
      buf_stamp <= '0;
      buf_valid <= 1'b0;
    end else begin
      buf_valid <= trace_valid;
      if (trace_valid) begin
        shift_buf <= {shift_buf[buf_width-nibble_width-1:0], trace_data};
        buf_stamp <= stamp;
      end
    end
  end

  assign buf_out = '{data: shift_buf, stamp: buf_stamp, valid: buf_valid};

endmodule

//--- hdl/pattern_matcher.sv
`timescale 1ns/10ps

module pattern_matcher (
  input  logic                                       fe_clk,
  input  logic                                       reset,
  input  trace_pkg::trace_buf_t                      buf_in,
  input  trace_pkg::rule_cfg_t [trace_pkg::num_rules-1:0] rules,
  input  logic [trace_pkg::num_rules-1:0]            pattern_enable,
  output trace_pkg::match_vec_t                      match_out
);
  import trace_pkg::*;

  logic [num_rules-1:0]   hit;
  logic [num_rules-1:0]   match_q;
  logic [stamp_width-1:0] stamp_q;

  // masked compare, only bits with mask=1 take part
  always_comb begin
    for (int r = 0; r < num_rules; r++) begin
      hit[r] = pattern_enable[r] &&
               (((buf_in.data ^ rules[r].pattern) & rules[r].mask) == '0);
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      match_q <= '0;
    end else if (buf_in.valid) begin
      match_q <= hit;
    end else begin
      match_q <= '0; // nothing new in the buffer
    end
  end

  always_ff @(posedge fe_clk) begin
    stamp_q <= buf_in.stamp;
  end

  assign match_out = '{match: match_q, stamp: stamp_q};

endmodule

//--- hdl/match_reporter.sv
`timescale 1ns/10ps

module match_reporter (
  input  logic                            fe_clk,
  input  logic                            reset,
  input  trace_pkg::match_vec_t           match_in,
  input  logic [trace_pkg::num_rules-1:0] trig_enable,
  input  logic                            clear_overflow,
  output trace_pkg::count_vec_t           counts,
  output logic                            overflow,
  output logic                            trig_out,
  output logic                            event_valid,
  input  logic                            event_ready,
  output trace_pkg::trace_event_t         event_data
);
  import trace_pkg::*;

  logic [rule_idx_width-1:0] first_idx;
  logic                      any_match;
  logic                      load_event;
  logic                      drop_event;

  // lowest set bit wins
  always_comb begin
    first_idx = '0;
    for (int r = num_rules - 1; r >= 0; r--) begin
      if (match_in.match[r]) begin
        first_idx = rule_idx_width'(r);
      end
    end
  end

  assign any_match  = |match_in.match;
  assign load_event = any_match && (!event_valid || event_ready); // empty, or replaced on accept
  assign drop_event = any_match && event_valid && !event_ready;

  // saturating per-rule counters that ignore back-pressure
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      counts <= '0;
    end else begin
      for (int r = 0; r < num_rules; r++) begin
        if (match_in.match[r] && (counts[r] != {count_width{1'b1}})) begin
          counts[r] <= counts[r] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      trig_out    <= 1'b0;
      event_valid <= 1'b0;
      overflow    <= 1'b0;
    end else begin
      trig_out <= |(match_in.match & trig_enable);
      if (load_event) begin
        event_valid <= 1'b1;
      end else if (event_ready) begin
        event_valid <= 1'b0;
      end
      if (clear_overflow) begin
        overflow <= 1'b0;
      end
      if (drop_event) begin
        overflow <= 1'b1; // a drop in the clear cycle still counts
      end
    end
  end

  // one-entry output register
  always_ff @(posedge fe_clk) begin
    if (load_event) begin
      event_data <= '{rule: first_idx, stamp: match_in.stamp};
    end
  end

  // held event stays put until the sink takes it
  event_held_stable: assert property (
    @(posedge fe_clk) disable iff (reset)
    (event_valid && !event_ready) |=> (event_valid && $stable(event_data)));

endmodule

//--- hdl/trace_top.sv
`timescale 1ns/10ps

module trace_top (
  input  logic                                 fe_clk,
  input  logic                                 reset,
  // apb
  input  logic [trace_pkg::apb_addr_width-1:0] paddr,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [trace_pkg::apb_data_width-1:0] pwdata,
  output logic [trace_pkg::apb_data_width-1:0] prdata,
  output logic                                 pready,
  output logic                                 pslverr,
  // trace capture
  input  logic [trace_pkg::nibble_width-1:0]   trace_data,
  input  logic                                 trace_valid,
  output logic                                 trig_out,
  // match events
  output logic                                 event_valid,
  input  logic                                 event_ready,
  output trace_pkg::trace_event_t              event_data
);
  import trace_pkg::*;

  rule_cfg_t [num_rules-1:0] rules;
  logic [num_rules-1:0]      pattern_enable;
  logic [num_rules-1:0]      trig_enable;
  logic                      clear_overflow;
  count_vec_t                counts;
  logic                      overflow;
  trace_buf_t                trace_buf;
  match_vec_t                match_vec;

  trace_apb_regs u_regs (
    .fe_clk, .reset,
    .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .rules, .pattern_enable, .trig_enable, .clear_overflow,
    .counts, .overflow
  );

  trace_shifter u_shifter (
    .fe_clk, .reset,
    .trace_data, .trace_valid,
    .buf_out (trace_buf)
  );

  pattern_matcher u_matcher (
    .fe_clk, .reset,
    .buf_in    (trace_buf),
    .rules, .pattern_enable,
    .match_out (match_vec)
  );

  match_reporter u_reporter (
    .fe_clk, .reset,
    .match_in (match_vec),
    .trig_enable, .clear_overflow, .counts, .overflow,
    .trig_out, .event_valid, .event_ready, .event_data
  );

endmodule

//--- verif/trace_tb.sv
`timescale 1ns/10ps

module trace_tb;
  import trace_pkg::*;

  localparam int clk_period      = 20;
  localparam int reset_cycles    = 16;
  localparam int cycles_per_line = 60;
  localparam     golden_path     = "verif/trace_golden.txt";

  logic                      fe_clk;
  logic                      reset;
  logic [apb_addr_width-1:0] paddr;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [apb_data_width-1:0] pwdata;
  logic [apb_data_width-1:0] prdata;
  logic                      pready;
  logic                      pslverr;
  logic [nibble_width-1:0]   trace_data;
  logic                      trace_valid;
  logic                      trig_out;
  logic                      event_valid;
  logic                      event_ready;
  trace_event_t              event_data;

  logic [stamp_width-1:0] cyc;        // what the DUT stamp counter should read
  logic [stamp_width-1:0] last_stamp; // stamp of the newest nibble sent
  int                     line_count;
  string                  test_name = "setup";

  trace_event_t           exp_events[$];
  bit                     exp_timed[$];  // event must land 3 cycles after its nibble
  logic [stamp_width-1:0] exp_trigs[$];  // cycle of each expected trigger pulse

  trace_top dut (
    .fe_clk, .reset,
    .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .trace_data, .trace_valid, .trig_out,
    .event_valid, .event_ready, .event_data
  );

  initial begin
    fe_clk = 1'b0;
    forever #(clk_period / 2) fe_clk = ~fe_clk;
  end

  // 0 in the first cycle after reset
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      cyc <= '0;
    end else begin
      cyc <= cyc + 1'b1;
    end
  end

  task automatic report_fail(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      report_fail($sformatf("FAIL %s %s expected %h actual %h",
                            test_name, what, expected, actual));
    end
  endtask

  // setup phase, access phase, then back to idle
  task automatic apb_access(input logic write, input logic [apb_addr_width-1:0] addr,
                            input logic [31:0] data, input logic exp_err);
    @(negedge fe_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = write ? data : '0;
    @(negedge fe_clk);
    penable = 1'b1;
    @(posedge fe_clk);
    check_value("pready", 32'd1, 32'(pready));
    check_value($sformatf("pslverr at %h", addr), 32'(exp_err), 32'(pslverr));
    if (!write) begin
      check_value($sformatf("prdata at %h", addr), data, prdata);
    end
    @(negedge fe_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic send_nibble(input logic [nibble_width-1:0] value);
    @(negedge fe_clk);
    trace_valid = 1'b1;
    trace_data  = value;
    last_stamp  = cyc; // sampled on the coming edge
    @(negedge fe_clk);
    trace_valid = 1'b0;
  endtask

  task automatic send_burst(input logic [nibble_width-1:0] value, input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge fe_clk);
      trace_valid = 1'b1;
      trace_data  = value;
      last_stamp  = cyc;
    end
    @(negedge fe_clk);
    trace_valid = 1'b0;
  endtask

  function automatic int count_lines();
    int               fd;
    int               lines;
    logic [8*128-1:0] line_buf;
    lines = 0;
    fd = $fopen(golden_path, "r");
    if (fd != 0) begin
      while ($fgets(line_buf, fd) != 0) begin
        lines++;
      end
      $fclose(fd);
    end
    return lines;
  endfunction

  // one golden command per line with hex fields
  task automatic run_golden();
    int               fd;
    int               got;
    logic [7:0]       op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      c;
    logic [8*128-1:0] rest;
    logic [8*16-1:0]  name_buf;
    trace_event_t     want;
    fd = $fopen(golden_path, "r");
    while ($fscanf(fd, " %c", op) == 1) begin
      case (op)
        "#": got = $fgets(rest, fd);
        "N": begin
          got = $fscanf(fd, "%s", name_buf);
          test_name = $sformatf("%0s", name_buf);
        end
        "W", "R": begin
          got = $fscanf(fd, "%h %h %h", a, b, c);
          apb_access(op == "W", a[apb_addr_width-1:0], b, c[0]);
        end
        "T": begin
          got = $fscanf(fd, "%h", a);
          repeat ($urandom % 3) @(negedge fe_clk); // random gap
          send_nibble(a[nibble_width-1:0]);
        end
        "B": begin
          got = $fscanf(fd, "%h %h", a, b);
          send_burst(a[nibble_width-1:0], b);
        end
        "I": begin
          got = $fscanf(fd, "%h", a);
          repeat (a) @(negedge fe_clk);
        end
        "Y": begin
          got = $fscanf(fd, "%h", a);
          @(negedge fe_clk);
          event_ready = a[0];
        end
        "E": begin
          got = $fscanf(fd, "%h %h", a, b);
          want.rule  = a[rule_idx_width-1:0];
          want.stamp = last_stamp;
          exp_events.push_back(want);
          exp_timed.push_back(b[0]);
        end
        "G": exp_trigs.push_back(last_stamp + 16'd3);
        default: report_fail($sformatf("unknown golden command '%c'", op));
      endcase
    end
    $fclose(fd);
  endtask

  task automatic finish_run();
    if (exp_events.size() != 0 || exp_trigs.size() != 0) begin
      report_fail($sformatf("%0d expected events and %0d expected triggers never came",
                            exp_events.size(), exp_trigs.size()));
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  endtask

  always @(posedge fe_clk) begin : event_monitor
    trace_event_t want;
    bit           timed;
    if (!reset && event_valid && event_ready) begin
      if (exp_events.size() == 0) begin
        report_fail($sformatf("unexpected event from rule %0d in cycle %0d",
                              event_data.rule, cyc));
      end else begin
        want  = exp_events.pop_front();
        timed = exp_timed.pop_front();
        check_value("event rule", 32'(want.rule), 32'(event_data.rule));
        check_value("event stamp", 32'(want.stamp), 32'(event_data.stamp));
        if (timed) begin
          check_value("event cycle", 32'(16'(want.stamp + 16'd3)), 32'(cyc));
        end
      end
    end
  end

  always @(posedge fe_clk) begin : trigger_monitor
    if (!reset && trig_out) begin
      if (exp_trigs.size() == 0) begin
        report_fail($sformatf("unexpected trigger pulse in cycle %0d", cyc));
      end else begin
        check_value("trigger cycle", 32'(exp_trigs.pop_front()), 32'(cyc));
      end
    end
  end

  initial begin : watchdog
    wait (line_count != 0);
    repeat (reset_cycles + line_count * cycles_per_line) @(posedge fe_clk);
    report_fail("timeout, the golden file did not finish in time");
  end

  initial begin : stimulus
    void'($urandom(6));
    reset       = 1'b1;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    trace_data  = '0;
    trace_valid = 1'b0;
    event_ready = 1'b1;
    last_stamp  = '0;
    line_count  = count_lines();
    if (line_count == 0) begin
      report_fail("golden file verif/trace_golden.txt is missing or empty");
    end else begin
      repeat (reset_cycles) @(negedge fe_clk);
      reset = 1'b0;
      run_golden();
      finish_run();
    end
  end

endmodule

//--- verif/trace_golden.txt
# N name | W addr data err | R addr data err | T nibble | B nibble count | I cycles
# Y ready | E rule timed | G    (E and G take the stamp of the newest nibble, all hex)
N regs
Y 1
W 20 12345678 0
R 20 12345678 0
W 2c a5a5a5a5 0
R 2c a5a5a5a5 0
W 9c deadbeef 0
R 9c deadbeef 0
W 00 ffff1234 0
R 00 00001234 0
W 10 00000055 1
R 10 00000000 1
R a0 00000000 1
R 04 00000000 0
R 08 00000000 0
N match
W 2c 00000000 0
W 40 00000abc 0
W 48 00000fff 0
W 00 00000404 0
T 1
T a
T b
T c
E 2 1
G
T 5
I 4
N priority
# rule 1 on nibble 7, rule 4 on byte 67 with trigger
W 30 00000007 0
W 38 0000000f 0
W 60 00000067 0
W 68 000000ff 0
W 00 00001016 0
T 6
T 7
E 1 1
G
T 3
T 7
E 1 1
I 4
R 08 00010200 0
R 0c 00000001 0
N overflow
Y 0
W 00 00001017 0
T 0
E 0 0
B 0 12c
I 4
R 08 000102ff 0
R 0c 00000001 0
R 04 00000001 0
W 04 00000001 0
R 04 00000000 0
Y 1
I 6

//--- compile.f
hdl/trace_pkg.sv
hdl/trace_apb_regs.sv
hdl/trace_shifter.sv
hdl/pattern_matcher.sv
hdl/match_reporter.sv
hdl/trace_top.sv
verif/trace_tb.sv

//--- Bender.yml
package:
  name: trace_frontend

sources:
  - files:
      - hdl/trace_pkg.sv
      - hdl/trace_apb_regs.sv
      - hdl/trace_shifter.sv
      - hdl/pattern_matcher.sv
      - hdl/match_reporter.sv
      - hdl/trace_top.sv
  - target: test
    files:
      - verif/trace_tb.sv
